// File: design/cart_loader_pkg.sv
/*
 * Shared definitions for the cartridge loader: iNES format constants,
 * loader state enum, decoded header struct and the packed mapper flag word
 */
package cart_loader_pkg;

	// Memory map
	localparam int ADDR_W         = 22;
	localparam int PRG_PAGE_SHIFT = 14; // 16 KiB PRG pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KiB CHR pages
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000;

	// iNES header layout
	localparam int HEADER_LEN = 16;

	localparam logic [7:0] INES_MAGIC0 = 8'h4E; // 'N'
	localparam logic [7:0] INES_MAGIC1 = 8'h45; // 'E'
	localparam logic [7:0] INES_MAGIC2 = 8'h53; // 'S'
	localparam logic [7:0] INES_MAGIC3 = 8'h1A;

	typedef enum logic [2:0] {
		HEADER,
		LOAD_PRG,
		LOAD_CHR,
		DONE,
		ERROR
	} loader_state_e;

	// Decoded view of the 16 header bytes
	typedef struct packed {
		logic [7:0] prg_pages;
		logic [7:0] chr_pages;
		logic       magic_ok;
		logic       has_trainer;
		logic [7:0] mapper;
		logic [7:0] submapper;   // Zero unless iNES 2.0
		logic [2:0] prg_size;
		logic [2:0] chr_size;
		logic       mirroring;   // Already adjusted by invert_mirroring
		logic       four_screen;
		logic       has_saves;
	} ines_info_t;

	// Flag word handed to the mapper logic, bit 0 is mapper[0]
	typedef struct packed {
		logic [5:0] zero;
		logic       has_saves;   // [25]
		logic [7:0] submapper;   // [24:17]
		logic       four_screen; // [16]
		logic       has_chr_ram; // [15]
		logic       mirroring;   // [14]
		logic [2:0] chr_size;    // [13:11]
		logic [2:0] prg_size;    // [10:8]
		logic [7:0] mapper;      // [7:0]
	} mapper_flags_t;

endpackage

// File: design/mem_write_if.sv
/*
 * Single memory write handshake from the loader to the staging buffer
 */
`timescale 1ns/1ps

interface mem_write_if;

	logic [cart_loader_pkg::ADDR_W-1:0] addr;
	logic [7:0]                         data;
	logic                               valid;
	logic                               ready;

	// Transfer when valid and ready are both high at a clock edge
	modport loader (
		output addr,
		output data,
		output valid,
		input  ready
	);

	modport stage (
		input  addr,
		input  data,
		input  valid,
		output ready
	);

endinterface

// File: design/ines_header_parser.sv
/*
 * iNES header capture and decode: magic and trainer check, iNES 2.0
 * detection, dirty header masking and PRG/CHR size codes
 */
`timescale 1ns/1ps

module ines_header_parser (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        start,
	input  logic                        invert_mirroring,
	input  logic                        byte_en,
	input  logic [7:0]                  byte_data,
	output cart_loader_pkg::ines_info_t info,
	output logic                        header_full
);

	logic [3:0] byte_cnt;
	logic [7:0] hdr_q [cart_loader_pkg::HEADER_LEN];
	logic [7:0] hdr_last;
	logic       is_nes20;
	logic       is_dirty;

	// Page count to power-of-two size code
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		if (pages <= 8'd1)
			return 3'd0;
		else if (pages <= 8'd2)
			return 3'd1;
		else if (pages <= 8'd4)
			return 3'd2;
		else if (pages <= 8'd8)
			return 3'd3;
		else if (pages <= 8'd16)
			return 3'd4;
		else if (pages <= 8'd32)
			return 3'd5;
		else if (pages <= 8'd64)
			return 3'd6;
		return 3'd7;
	endfunction

	assign header_full = byte_en && (byte_cnt == 4'(cart_loader_pkg::HEADER_LEN - 1));

	always_ff @(posedge clk) begin
		if (reset_nes || start)
			byte_cnt <= '0;
		else if (byte_en)
			byte_cnt <= byte_cnt + 4'd1; // Wraps to 0 after the last byte
	end

	always_ff @(posedge clk) begin
		if (byte_en)
			hdr_q[byte_cnt] <= byte_data;
	end

	// Byte 15 arrives in the same cycle the loader acts on header_full
	assign hdr_last = header_full ? byte_data : hdr_q[15];

	assign is_nes20 = (hdr_q[7][3:2] == 2'b10);

	// Junk in bytes 9..15 marks an old tool that wrote past the 1.0 fields
	assign is_dirty = !is_nes20 && ((hdr_q[9][7:1] != 7'd0) ||
		(hdr_q[10] != 8'd0) || (hdr_q[11] != 8'd0) || (hdr_q[12] != 8'd0) ||
		(hdr_q[13] != 8'd0) || (hdr_q[14] != 8'd0) || (hdr_last != 8'd0));

	always_comb begin
		info.prg_pages   = hdr_q[4];
		info.chr_pages   = hdr_q[5];
		info.magic_ok    = (hdr_q[0] == cart_loader_pkg::INES_MAGIC0) &&
			(hdr_q[1] == cart_loader_pkg::INES_MAGIC1) &&
			(hdr_q[2] == cart_loader_pkg::INES_MAGIC2) &&
			(hdr_q[3] == cart_loader_pkg::INES_MAGIC3);
		info.has_trainer = hdr_q[6][2];
		info.mapper      = {is_dirty ? 4'h0 : hdr_q[7][7:4], hdr_q[6][7:4]};
		info.submapper   = is_nes20 ? hdr_q[8] : 8'h00;
		info.prg_size    = size_code(hdr_q[4]);
		info.chr_size    = size_code(hdr_q[5]);
		info.mirroring   = hdr_q[6][0] ^ invert_mirroring;
		info.four_screen = hdr_q[6][3];
		info.has_saves   = hdr_q[6][1]; // Battery backed RAM
	end

endmodule

// File: design/rom_loader_fsm.sv
/*
 * Load state machine: header handoff, PRG and CHR byte counting,
 * write address generation, mapper flag capture and done/error
 */
`timescale 1ns/1ps

module rom_loader_fsm (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           start,
	input  logic [7:0]                     in_data,
	input  logic                           in_valid,
	input  cart_loader_pkg::ines_info_t    info,
	input  logic                           header_full,
	output logic                           in_ready,
	output logic                           header_byte_en,
	output cart_loader_pkg::mapper_flags_t mapper_flags,
	output logic                           done,
	output logic                           error,
	mem_write_if.loader                    wr
);

	cart_loader_pkg::loader_state_e     state;
	cart_loader_pkg::loader_state_e     next_state;
	cart_loader_pkg::loader_state_e     hdr_next;
	cart_loader_pkg::mapper_flags_t     flags_now;
	logic [cart_loader_pkg::ADDR_W-1:0] bytes_left;
	logic [cart_loader_pkg::ADDR_W-1:0] addr_q;
	logic [cart_loader_pkg::ADDR_W-1:0] prg_bytes;
	logic [cart_loader_pkg::ADDR_W-1:0] chr_bytes;
	logic                               loading;
	logic                               have_bytes;
	logic                               wr_fire;
	logic                               last_byte;

	assign prg_bytes = {{(cart_loader_pkg::ADDR_W-8){1'b0}}, info.prg_pages}
		<< cart_loader_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = {{(cart_loader_pkg::ADDR_W-8){1'b0}}, info.chr_pages}
		<< cart_loader_pkg::CHR_PAGE_SHIFT;

	assign loading    = (state == cart_loader_pkg::LOAD_PRG) ||
		(state == cart_loader_pkg::LOAD_CHR);
	assign have_bytes = (bytes_left != '0);

	// Payload bytes go straight to the staging buffer
	assign wr.valid = loading && have_bytes && in_valid;
	assign wr.addr  = addr_q;
	assign wr.data  = in_data;
	assign wr_fire  = wr.valid && wr.ready;
	assign last_byte = wr_fire && (bytes_left == 1);

	assign in_ready = (state == cart_loader_pkg::HEADER) || (loading && have_bytes && wr.ready);
	assign header_byte_en = (state == cart_loader_pkg::HEADER) && in_valid;

	// Where the header sends us, skipping empty regions
	always_comb begin
		if (!info.magic_ok || info.has_trainer)
			hdr_next = cart_loader_pkg::ERROR;
		else if (info.prg_pages != 8'd0)
			hdr_next = cart_loader_pkg::LOAD_PRG;
		else if (info.chr_pages != 8'd0)
			hdr_next = cart_loader_pkg::LOAD_CHR;
		else
			hdr_next = cart_loader_pkg::DONE;
	end

	always_comb begin
		next_state = state;
		case (state)
			cart_loader_pkg::HEADER:
				if (header_full)
					next_state = hdr_next;
			cart_loader_pkg::LOAD_PRG:
				if (last_byte)
					next_state = (info.chr_pages != 8'd0) ? cart_loader_pkg::LOAD_CHR
						: cart_loader_pkg::DONE;
			cart_loader_pkg::LOAD_CHR:
				if (last_byte)
					next_state = cart_loader_pkg::DONE;
			default: ; // DONE and ERROR wait for start
		endcase
	end

	always_comb begin
		flags_now             = '0;
		flags_now.mapper      = info.mapper;
		flags_now.prg_size    = info.prg_size;
		flags_now.chr_size    = info.chr_size;
		flags_now.mirroring   = info.mirroring;
		flags_now.has_chr_ram = (info.chr_pages == 8'd0);
		flags_now.four_screen = info.four_screen;
		flags_now.submapper   = info.submapper;
		flags_now.has_saves   = info.has_saves;
	end

	always_ff @(posedge clk) begin
		if (reset_nes || start) begin
			state        <= cart_loader_pkg::HEADER;
			bytes_left   <= '0;
			addr_q       <= '0;
			mapper_flags <= '0;
			done         <= 1'b0;
			error        <= 1'b0;
		end else begin
			state <= next_state;
			if (next_state != state) begin
				case (next_state)
					cart_loader_pkg::LOAD_PRG: begin
						bytes_left <= prg_bytes;
						addr_q     <= '0; // PRG starts at address 0
					end
					cart_loader_pkg::LOAD_CHR: begin
						bytes_left <= chr_bytes;
						addr_q     <= cart_loader_pkg::CHR_BASE;
					end
					cart_loader_pkg::ERROR: begin
						mapper_flags <= flags_now;
						done         <= 1'b1;
						error        <= 1'b1;
					end
					default: begin
						mapper_flags <= flags_now;
						done         <= 1'b1;
					end
				endcase
			end else if (wr_fire) begin
				bytes_left <= bytes_left - 1'b1;
				addr_q     <= addr_q + 1'b1;
			end
		end
	end

	// A load region is only entered with bytes to move
	a_region_not_empty: assert property (@(posedge clk) disable iff (reset_nes)
		(loading && (state != $past(state))) |-> have_bytes);

	// Status only ever describes a finished or rejected image
	a_status_not_in_header: assert property (@(posedge clk) disable iff (reset_nes)
		(done || error) |-> (state != cart_loader_pkg::HEADER));

endmodule

// File: design/mem_write_stage.sv
/*
 * One-entry staging buffer between the loader and the memory port
 */
`timescale 1ns/1ps

module mem_write_stage (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  logic                               mem_ready,
	output logic [cart_loader_pkg::ADDR_W-1:0] mem_addr,
	output logic [7:0]                         mem_data,
	output logic                               mem_valid,
	mem_write_if.stage                         wr
);

	logic                               full;
	logic [cart_loader_pkg::ADDR_W-1:0] addr_q;
	logic [7:0]                         data_q;
	logic                               take;

	// Accept when empty or when the held write leaves this cycle
	assign wr.ready = !full || mem_ready;
	assign take     = wr.valid && wr.ready;

	always_ff @(posedge clk) begin
		if (reset_nes)
			full <= 1'b0;
		else if (take)
			full <= 1'b1;
		else if (mem_ready)
			full <= 1'b0; // Drained with nothing new behind it
	end

	always_ff @(posedge clk) begin
		if (take) begin
			addr_q <= wr.addr;
			data_q <= wr.data;
		end
	end

	assign mem_valid = full;
	assign mem_addr  = addr_q;
	assign mem_data  = data_q;

	// A stalled write holds until memory takes it
	a_hold_under_stall: assert property (@(posedge clk) disable iff (reset_nes)
		(mem_valid && !mem_ready) |=>
		(mem_valid && $stable(mem_addr) && $stable(mem_data)));

endmodule

// File: design/cart_loader_top.sv
/*
 * Cartridge loader top level: header parser, load FSM and write stage
 */
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  logic                               start,
	input  logic                               invert_mirroring,
	input  logic [7:0]                         in_data,
	input  logic                               in_valid,
	output logic                               in_ready,
	output logic [cart_loader_pkg::ADDR_W-1:0] mem_addr,
	output logic [7:0]                         mem_data,
	output logic                               mem_valid,
	input  logic                               mem_ready,
	output cart_loader_pkg::mapper_flags_t     mapper_flags,
	output logic                               done,
	output logic                               error
);

	cart_loader_pkg::ines_info_t info;
	logic                        header_full;
	logic                        header_byte_en;

	mem_write_if wr_bus ();

	ines_header_parser u_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.start            (start),
		.invert_mirroring (invert_mirroring),
		.byte_en          (header_byte_en),
		.byte_data        (in_data),
		.info             (info),
		.header_full      (header_full)
	);

	rom_loader_fsm u_fsm (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.start          (start),
		.in_data        (in_data),
		.in_valid       (in_valid),
		.info           (info),
		.header_full    (header_full),
		.in_ready       (in_ready),
		.header_byte_en (header_byte_en),
		.mapper_flags   (mapper_flags),
		.done           (done),
		.error          (error),
		.wr             (wr_bus.loader)
	);

	mem_write_stage u_stage (
		.clk       (clk),
		.reset_nes (reset_nes),
		.mem_ready (mem_ready),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.mem_valid (mem_valid),
		.wr        (wr_bus.stage)
	);

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset: 4 ns clock, reset held for 5 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset_nes
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		reset_nes = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0; // Released away from the sampling edge
	end

endmodule

// File: verif/cart_loader_tb.sv
/*
 * Table-driven testbench for cart_loader_top: header and payload stream,
 * randomized memory ready with in-order write checks, flag and status checks
 */
`timescale 1ns/1ps

module cart_loader_tb;

	localparam int AW             = cart_loader_pkg::ADDR_W;
	localparam int NUM_ROWS       = 6;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;
	localparam int SEED           = 40;
	localparam int RESET_LIMIT    = 50;
	localparam int STALL_LIMIT    = 1000; // Cycles one byte may wait for in_ready
	localparam int DONE_LIMIT     = 100;
	localparam int WRITE_LIMIT    = 1000;

	typedef struct packed {
		logic [15:0][7:0]               hdr;       // hdr[0] is the first byte sent
		logic                           invert;
		logic [6:0]                     bp_pct;    // Chance of mem_ready low, percent
		cart_loader_pkg::mapper_flags_t flags;
		logic                           error;
		logic [21:0]                    prg_count;
		logic [21:0]                    chr_count;
	} row_t;

	logic                           clk;
	logic                           reset_nes;
	logic                           start;
	logic                           invert_mirroring;
	logic [7:0]                     in_data;
	logic                           in_valid;
	logic                           in_ready;
	logic [AW-1:0]                  mem_addr;
	logic [7:0]                     mem_data;
	logic                           mem_valid;
	logic                           mem_ready;
	cart_loader_pkg::mapper_flags_t mapper_flags;
	logic                           done;
	logic                           error;

	row_t        rows [NUM_ROWS];
	int unsigned exp_prg;       // PRG bytes of the current row
	int unsigned exp_total;
	int unsigned bp_pct;
	int unsigned writes_taken;
	int          failures = 0;

	tb_clock_gen clock_gen (
		.clk       (clk),
		.reset_nes (reset_nes)
	);

	cart_loader_top dut0 (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.start            (start),
		.invert_mirroring (invert_mirroring),
		.in_data          (in_data),
		.in_valid         (in_valid),
		.in_ready         (in_ready),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_valid        (mem_valid),
		.mem_ready        (mem_ready),
		.mapper_flags     (mapper_flags),
		.done             (done),
		.error            (error)
	);

	task automatic report_mismatch(input string msg);
		failures++;
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Errors found");
		$fatal(1, "Simulation stopped by a timeout");
	endtask

	task automatic check_flags(input cart_loader_pkg::mapper_flags_t got,
		input cart_loader_pkg::mapper_flags_t exp);
		if (got !== exp)
			report_mismatch($sformatf("mapper_flags %h, expected %h", got, exp));
	endtask

	task automatic check_write(input logic [AW-1:0] got_addr, input logic [7:0] got_data,
		input logic [AW-1:0] exp_addr, input logic [7:0] exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data)
			report_mismatch($sformatf("write %0d: got %h at %h, expected %h at %h",
				writes_taken, got_data, got_addr, exp_data, exp_addr));
	endtask

	task automatic check_status(input logic got_done, input logic got_error,
		input logic exp_done, input logic exp_error, input string when);
		if (got_done !== exp_done || got_error !== exp_error)
			report_mismatch($sformatf("%s: done %b error %b, expected %b %b",
				when, got_done, got_error, exp_done, exp_error));
	endtask

	// Standard 16-byte header, junk lands in bytes 12 and 15
	function automatic logic [15:0][7:0] ines_header(input logic [7:0] magic3,
		input logic [7:0] prg, input logic [7:0] chr, input logic [7:0] f6,
		input logic [7:0] f7, input logic [7:0] f8, input logic [7:0] junk12,
		input logic [7:0] junk15);
		logic [15:0][7:0] h;
		h     = '0;
		h[0]  = 8'h4E; // N
		h[1]  = 8'h45; // E
		h[2]  = 8'h53; // S
		h[3]  = magic3;
		h[4]  = prg;
		h[5]  = chr;
		h[6]  = f6;
		h[7]  = f7;
		h[8]  = f8;
		h[12] = junk12;
		h[15] = junk15;
		return h;
	endfunction

	function automatic cart_loader_pkg::mapper_flags_t make_flags(input logic [7:0] mapper,
		input logic [2:0] prg_size, input logic [2:0] chr_size, input logic mirroring,
		input logic chr_ram, input logic four_screen, input logic [7:0] submapper,
		input logic has_saves);
		cart_loader_pkg::mapper_flags_t f;
		f             = '0;
		f.mapper      = mapper;
		f.prg_size    = prg_size;
		f.chr_size    = chr_size;
		f.mirroring   = mirroring;
		f.has_chr_ram = chr_ram;
		f.four_screen = four_screen;
		f.submapper   = submapper;
		f.has_saves   = has_saves;
		return f;
	endfunction

	task automatic set_row(input int idx, input logic [15:0][7:0] hdr, input logic invert,
		input int bp, input cart_loader_pkg::mapper_flags_t flags, input logic err,
		input int prg_pages, input int chr_pages);
		rows[idx].hdr       = hdr;
		rows[idx].invert    = invert;
		rows[idx].bp_pct    = 7'(bp);
		rows[idx].flags     = flags;
		rows[idx].error     = err;
		rows[idx].prg_count = 22'(prg_pages * PRG_PAGE_BYTES);
		rows[idx].chr_count = 22'(chr_pages * CHR_PAGE_BYTES);
	endtask

	task automatic build_table();
		// Plain 1.0, mapper 0x21, CHR RAM
		set_row(0, ines_header(8'h1A, 8'd1, 8'd0, 8'h11, 8'h20, 8'h00, 8'h00, 8'h00), 1'b0,
			20, make_flags(8'h21, 3'd0, 3'd0, 1'b1, 1'b1, 1'b0, 8'h00, 1'b0), 1'b0, 1, 0);
		// Dirty 1.0, upper nibble 3 must be dropped
		set_row(1, ines_header(8'h1A, 8'd2, 8'd1, 8'h40, 8'h30, 8'h07, 8'h44, 8'h55), 1'b0,
			10, make_flags(8'h04, 3'd1, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0), 1'b0, 2, 1);
		set_row(2, ines_header(8'h1B, 8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00), 1'b0,
			0, '0, 1'b1, 0, 0); // Bad magic
		// iNES 2.0, junk in byte 12 is legal here
		set_row(3, ines_header(8'h1A, 8'd1, 8'd2, 8'h2B, 8'h18, 8'h35, 8'h07, 8'h00), 1'b1,
			30, make_flags(8'h12, 3'd0, 3'd1, 1'b0, 1'b0, 1'b1, 8'h35, 1'b1), 1'b0, 1, 2);
		set_row(4, ines_header(8'h1A, 8'd1, 8'd0, 8'h04, 8'h00, 8'h00, 8'h00, 8'h00), 1'b0,
			0, '0, 1'b1, 0, 0); // Trainer present
		rows[5]        = rows[1];
		rows[5].bp_pct = 7'd75; // Same image under heavy stall
	endtask

	// PRG from 0, then CHR from its base
	function automatic logic [AW-1:0] expected_addr(input int unsigned n);
		int unsigned chr_off;
		if (n < exp_prg)
			return n[AW-1:0];
		chr_off = n - exp_prg;
		return 22'h200000 + chr_off[AW-1:0];
	endfunction

	// Entered on a falling edge, returns on the falling edge after the transfer
	task automatic send_byte(input logic [7:0] value);
		int waited;
		waited   = 0;
		in_data  = value;
		in_valid = 1'b1;
		#1;
		while (!in_ready) begin
			if (waited == STALL_LIMIT)
				report_timeout("in_ready");
			waited++;
			@(negedge clk);
			#1;
		end
		@(negedge clk);
	endtask

	task automatic run_row(input int r);
		int unsigned total;
		int unsigned n;
		int          waited;
		total            = rows[r].prg_count + rows[r].chr_count;
		exp_prg          = rows[r].prg_count;
		exp_total        = total;
		bp_pct           = rows[r].bp_pct;
		writes_taken     = 0;
		invert_mirroring = rows[r].invert;
		start            = 1'b1;
		@(negedge clk);
		start = 1'b0;
		#1;
		check_status(done, error, 1'b0, 1'b0, "after start");
		if (in_ready !== 1'b1)
			report_mismatch("in_ready low while waiting for the header");
		@(negedge clk);
		for (int b = 0; b < 16; b++)
			send_byte(rows[r].hdr[b]);
		for (n = 0; n < total; n++)
			send_byte(n[7:0]); // Payload byte is its running index
		in_valid = 1'b0;

		waited = 0;
		#1;
		while (!done) begin
			if (waited == DONE_LIMIT)
				report_timeout("done");
			waited++;
			@(negedge clk);
			#1;
		end
		check_status(done, error, 1'b1, rows[r].error, "at done");
		if (rows[r].error) begin
			if (in_ready !== 1'b0)
				report_mismatch("in_ready high after a rejected header");
		end else begin
			check_flags(mapper_flags, rows[r].flags);
		end

		waited = 0;
		@(negedge clk);
		while (writes_taken < total) begin
			if (waited == WRITE_LIMIT)
				report_timeout("memory writes to drain");
			waited++;
			@(negedge clk);
		end
		$display("Row %0d finished with %0d writes", r, writes_taken);
	endtask

	// Memory side: random ready, every accepted write checked in order
	initial begin : memory_model
		void'($urandom(SEED));
		mem_ready = 1'b0;
		forever begin
			@(negedge clk);
			mem_ready = (($urandom % 100) >= bp_pct);
			#1;
			if (mem_valid && mem_ready) begin
				if (writes_taken >= exp_total)
					report_mismatch($sformatf("unexpected write %h at %h", mem_data, mem_addr));
				else
					check_write(mem_addr, mem_data, expected_addr(writes_taken), writes_taken[7:0]);
				writes_taken++;
			end
		end
	end

	initial begin : stimulus
		int waited;
		start            = 1'b0;
		invert_mirroring = 1'b0;
		in_data          = 8'h00;
		in_valid         = 1'b0;
		exp_prg          = 0;
		exp_total        = 0;
		bp_pct           = 0;
		writes_taken     = 0;
		build_table();
		waited = 0;
		@(negedge clk);
		while (reset_nes) begin
			if (waited == RESET_LIMIT)
				report_timeout("reset release");
			waited++;
			@(negedge clk);
		end
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		if (failures == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Checks failed");
		end
	end

endmodule

// File: tb.f
design/cart_loader_pkg.sv
design/mem_write_if.sv
design/ines_header_parser.sv
design/rom_loader_fsm.sv
design/mem_write_stage.sv
design/cart_loader_top.sv
verif/tb_clock_gen.sv
verif/cart_loader_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cart_loader_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
